/* common/soc_pkg.sv */
/*
 * Shared definitions for the peripheral fabric
 * Memory map, bus request/response structs, SPI pin group and default sizes
 */
package soc_pkg;

    // Region select, address bits 31..28
    localparam logic [3:0] REGION_RAM = 4'h1;
    localparam logic [3:0] REGION_IO  = 4'h2;

    // I/O pages, address bits 15..12
    localparam logic [3:0] PAGE_DISPLAY = 4'h1;
    localparam logic [3:0] PAGE_KBD     = 4'h5;
    localparam logic [3:0] PAGE_SD      = 4'h6;

    // Keyboard register offsets
    localparam logic [11:0] OFS_STATUS = 12'h000;
    localparam logic [11:0] OFS_CODE   = 12'h004;

    // SD card register offset
    localparam logic [11:0] OFS_SPI = 12'h000;

    // Default sizes
    localparam int DEFAULT_RAM_WORDS    = 4096;
    localparam int DEFAULT_KBD_ADDR_LEN = 5;

    // Master request, held stable until ack
    typedef struct packed {
        logic        sel;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
    } bus_req_t;

    // Slave response, rdata valid while ack is high
    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } bus_rsp_t;

    // Bit-banged SPI outputs
    typedef struct packed {
        logic sclk;
        logic csn;
        logic mosi;
    } spi_pins_t;

endpackage

/* keyboard/kbd_fifo.sv */
/*
 * Synchronous circular FIFO with empty and full flags
 * Enqueue ignored when full, dequeue ignored when empty
 */
`timescale 1ns/10ps

module kbd_fifo import soc_pkg::*; #(
    parameter int ADDR_LEN = DEFAULT_KBD_ADDR_LEN,
    parameter int WIDTH    = 8
) (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic [WIDTH-1:0] d_i,
    input  wire logic             enq_i,
    output      logic             full_o,
    output      logic [WIDTH-1:0] q_o,
    input  wire logic             deq_i,
    output      logic             empty_o
);

    localparam int DEPTH = 2 ** ADDR_LEN;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [ADDR_LEN-1:0] wr_ptr;
    logic [ADDR_LEN-1:0] rd_ptr;
    logic [ADDR_LEN:0]   count;
    logic                do_enq;
    logic                do_deq;

    assign empty_o = count == '0;
    assign full_o  = count == (ADDR_LEN+1)'(DEPTH);
    assign do_enq  = enq_i && !full_o;
    assign do_deq  = deq_i && !empty_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_deq)
                rd_ptr <= rd_ptr + 1'b1;
            // Count unchanged on a simultaneous push and pop
            if (do_enq && !do_deq)
                count <= count + 1'b1;
            else if (do_deq && !do_enq)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq)
            mem[wr_ptr] <= d_i;
    end

    assign q_o = mem[rd_ptr];

endmodule

/* keyboard/kbd_port.sv */
/*
 * PS/2 keyboard code port
 * Queues strobed codes and pops one into the held code register per request
 */
`timescale 1ns/10ps

module kbd_port import soc_pkg::*; #(
    parameter int KBD_ADDR_LEN = DEFAULT_KBD_ADDR_LEN
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic [7:0] code_i,
    input  wire logic       strobe_i,
    input  wire logic       deq_req_i,
    output      logic       not_empty_o,
    output      logic [7:0] code_o
);

    logic       enq;
    logic       deq_q;
    logic       fifo_full;
    logic       fifo_empty;
    logic [7:0] fifo_q;
    logic [7:0] code_q;

    // Codes arriving while full are dropped
    assign enq = strobe_i && !fifo_full;

    kbd_fifo #(
        .ADDR_LEN(KBD_ADDR_LEN),
        .WIDTH   (8)
    ) kbd_fifo_i (
        .clk    (clk),
        .reset_i(reset_i),
        .d_i    (code_i),
        .enq_i  (enq),
        .full_o (fifo_full),
        .q_o    (fifo_q),
        .deq_i  (deq_q),
        .empty_o(fifo_empty)
    );

    // Each request makes a one-cycle pop that captures the head
    always_ff @(posedge clk) begin
        if (reset_i) begin
            deq_q  <= 1'b0;
            code_q <= 8'd0;
        end else begin
            deq_q <= deq_req_i && !fifo_empty && !deq_q;
            if (deq_q)
                code_q <= fifo_q;
        end
    end

    assign not_empty_o = !fifo_empty;
    assign code_o      = code_q;

endmodule

/* bus/bus_decoder.sv */
/*
 * Bus decoder for RAM and I/O regions
 * Device ack, one-cycle write strobes and the I/O read-data mux
 */
`timescale 1ns/10ps

module bus_decoder import soc_pkg::*; (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire bus_req_t   bus_req_i,
    output      bus_rsp_t   io_rsp_o,
    output      logic       ram_sel_o,
    output      logic       display_we_o,
    output      logic       sd_we_o,
    output      logic       kbd_deq_req_o,
    input  wire logic       kbd_not_empty_i,
    input  wire logic [7:0] kbd_code_i,
    input  wire logic       sd_miso_i
);

    logic        is_ram;
    logic        is_io;
    logic [3:0]  page;
    logic [11:0] offset;
    logic        wr_cycle;
    logic        ack_q;
    logic [31:0] rdata_d;
    logic [31:0] rdata_q;

    assign is_ram = bus_req_i.addr[31:28] == REGION_RAM;
    assign is_io  = bus_req_i.addr[31:28] == REGION_IO;
    assign page   = bus_req_i.addr[15:12];
    assign offset = bus_req_i.addr[11:0];

    assign ram_sel_o = bus_req_i.sel && is_ram;

    // First cycle of an I/O write; the ack cycle is excluded
    assign wr_cycle = bus_req_i.sel && bus_req_i.we && is_io && !ack_q;

    assign display_we_o  = wr_cycle && (page == PAGE_DISPLAY);
    assign sd_we_o       = wr_cycle && (page == PAGE_SD) && (offset == OFS_SPI);
    assign kbd_deq_req_o = wr_cycle && (page == PAGE_KBD) && (offset == OFS_STATUS);

    always_comb begin
        rdata_d = 32'd0;
        if (is_io) begin
            case (page)
                PAGE_KBD: begin
                    if (offset == OFS_STATUS)
                        rdata_d = {31'd0, kbd_not_empty_i};
                    else if (offset == OFS_CODE)
                        rdata_d = {24'd0, kbd_code_i};
                end
                PAGE_SD: begin
                    if (offset == OFS_SPI)
                        rdata_d = {31'd0, sd_miso_i};
                end
                default: rdata_d = 32'd0;
            endcase
        end
    end

    // Everything outside RAM is answered here, mapped or not
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req_i.sel && !is_ram && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req_i.sel && !ack_q)
            rdata_q <= bus_req_i.we ? 32'd0 : rdata_d;
    end

    assign io_rsp_o.ack   = ack_q;
    assign io_rsp_o.rdata = rdata_q;

endmodule

/* verilog/ram_bank.sv */
/*
 * Word-addressed RAM with per-byte write mask
 * Registered read data, ack one cycle after select
 */
`timescale 1ns/10ps

module ram_bank import soc_pkg::*; #(
    parameter int RAM_WORDS = DEFAULT_RAM_WORDS
) (
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     sel_i,
    input  wire bus_req_t bus_req_i,
    output      bus_rsp_t ram_rsp_o
);

    // Power-of-two size, so the slice wraps the address modulo RAM_WORDS
    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             ack_q;
    logic [31:0]      rdata_q;
    logic             access;

    assign idx    = bus_req_i.addr[IDX_W+1:2];
    assign access = sel_i && !ack_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte lanes written only where the mask bit is set
    always_ff @(posedge clk) begin
        if (access && bus_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req_i.mask[b])
                    mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access)
            rdata_q <= mem[idx];
    end

    assign ram_rsp_o.ack   = ack_q;
    assign ram_rsp_o.rdata = rdata_q;

endmodule

/* verilog/io_regs.sv */
/*
 * Display register and SD card SPI pin register
 * Both load from the write data bus on their decoder strobe
 */
`timescale 1ns/10ps

module io_regs import soc_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        display_we_i,
    input  wire logic        sd_we_i,
    input  wire logic [31:0] wdata_i,
    output      logic [7:0]  display_o,
    output      spi_pins_t   sd_pins_o
);

    logic [7:0] display_q;
    spi_pins_t  sd_pins_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_q <= 8'd0;
        end else if (display_we_i) begin
            display_q <= wdata_i[7:0];
        end
    end

    // Bit 1 is the active-high select seen by software, the pin is active low
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sd_pins_q.sclk <= 1'b0;
            sd_pins_q.csn  <= 1'b1;
            sd_pins_q.mosi <= 1'b0;
        end else if (sd_we_i) begin
            sd_pins_q.sclk <= wdata_i[2];
            sd_pins_q.csn  <= ~wdata_i[1];
            sd_pins_q.mosi <= wdata_i[0];
        end
    end

    assign display_o = display_q;
    assign sd_pins_o = sd_pins_q;

endmodule

/* verilog/soc_top.sv */
/*
 * Peripheral fabric top level
 * Joins decoder, RAM, I/O registers and keyboard port on one request bus
 */
`timescale 1ns/10ps

module soc_top import soc_pkg::*; #(
    parameter int RAM_WORDS    = DEFAULT_RAM_WORDS,
    parameter int KBD_ADDR_LEN = DEFAULT_KBD_ADDR_LEN
) (
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire bus_req_t   bus_req_i,
    output      bus_rsp_t   bus_rsp_o,
    output      logic [7:0] display_o,
    output      spi_pins_t  sd_pins_o,
    input  wire logic       sd_miso_i,
    input  wire logic [7:0] kbd_code_i,
    input  wire logic       kbd_strobe_i
);

    bus_rsp_t   io_rsp;
    bus_rsp_t   ram_rsp;
    logic       ram_sel;
    logic       display_we;
    logic       sd_we;
    logic       kbd_deq_req;
    logic       kbd_not_empty;
    logic [7:0] kbd_code;

    bus_decoder bus_decoder_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_req_i      (bus_req_i),
        .io_rsp_o       (io_rsp),
        .ram_sel_o      (ram_sel),
        .display_we_o   (display_we),
        .sd_we_o        (sd_we),
        .kbd_deq_req_o  (kbd_deq_req),
        .kbd_not_empty_i(kbd_not_empty),
        .kbd_code_i     (kbd_code),
        .sd_miso_i      (sd_miso_i)
    );

    ram_bank #(
        .RAM_WORDS(RAM_WORDS)
    ) ram_bank_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .sel_i    (ram_sel),
        .bus_req_i(bus_req_i),
        .ram_rsp_o(ram_rsp)
    );

    io_regs io_regs_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .display_we_i(display_we),
        .sd_we_i     (sd_we),
        .wdata_i     (bus_req_i.wdata),
        .display_o   (display_o),
        .sd_pins_o   (sd_pins_o)
    );

    kbd_port #(
        .KBD_ADDR_LEN(KBD_ADDR_LEN)
    ) kbd_port_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .code_i     (kbd_code_i),
        .strobe_i   (kbd_strobe_i),
        .deq_req_i  (kbd_deq_req),
        .not_empty_o(kbd_not_empty),
        .code_o     (kbd_code)
    );

    // Ack from whichever slave answered
    assign bus_rsp_o.ack   = ram_rsp.ack | io_rsp.ack;
    assign bus_rsp_o.rdata = (bus_req_i.addr[31:28] == REGION_RAM) ? ram_rsp.rdata
                                                                   : io_rsp.rdata;

endmodule

/* tb/tb_clock.sv */
/*
 * Testbench clock and reset generator
 * 20 ns clock, reset held high for the first cycles
 */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, like every other DUT input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_o = 1'b0;
    end

endmodule

/* tb/soc_tb.sv */
/*
 * Testbench for the peripheral fabric
 * Acts as bus master from the stim file and checks read data and pins
 */
`timescale 1ns/10ps

module soc_tb import soc_pkg::*; ();

    localparam int RAM_WORDS = DEFAULT_RAM_WORDS;

    logic       clk;
    logic       reset;
    bus_req_t   bus_req;
    bus_rsp_t   bus_rsp;
    logic [7:0] display;
    spi_pins_t  sd_pins;
    logic       sd_miso;
    logic [7:0] kbd_code;
    logic       kbd_strobe;

    string       stim_lines[$];
    string       test_name = "";
    logic [31:0] ram_model [int unsigned];
    logic [31:0] lfsr_state;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    tb_clock tb_clock_i (
        .clk    (clk),
        .reset_o(reset)
    );

    soc_top soc_top_i (
        .clk         (clk),
        .reset_i     (reset),
        .bus_req_i   (bus_req),
        .bus_rsp_o   (bus_rsp),
        .display_o   (display),
        .sd_pins_o   (sd_pins),
        .sd_miso_i   (sd_miso),
        .kbd_code_i  (kbd_code),
        .kbd_strobe_i(kbd_strobe)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    function automatic int random_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            gap = gap * 2 + int'(lfsr_state[0]);
        end
        return gap;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                word[8*b +: 8] = new_word[8*b +: 8];
        end
        return word;
    endfunction

    function automatic int unsigned ram_key(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = addr >> 2;
        return word_addr % 32'(RAM_WORDS);
    endfunction

    function automatic string strip_end(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" || r.getc(r.len() - 1) == "\r"
                               || r.getc(r.len() - 1) == " "))
            r = r.substr(0, r.len() - 2);
        return r;
    endfunction

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("Fail at %0d ns: %s expected %h actual %h", $time, sig, expected, actual);
            note_error();
        end
    endtask

    // Sel is held until ack, then dropped on the same falling edge
    task automatic bus_access(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] mask,
                              output logic [31:0] rdata);
        int  waited;
        logic got_ack;
        @(negedge clk);
        repeat (random_gap()) @(negedge clk);
        bus_req.sel   = 1'b1;
        bus_req.we    = we;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.mask  = mask;
        got_ack = 1'b0;
        waited  = 0;
        rdata   = 32'd0;
        while (!got_ack && waited < 4) begin
            @(negedge clk);
            waited++;
            if (bus_rsp.ack) begin
                got_ack = 1'b1;
                rdata   = bus_rsp.rdata;
            end
        end
        bus_req.sel = 1'b0;
        checks++;
        assert (got_ack) else begin
            $display("Error at %0d ns: no ack within 4 cycles of sel, address %h", $time, addr);
            note_error();
        end
    endtask

    task automatic write_op(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        logic [31:0] unused_rdata;
        int unsigned key;
        bus_access(1'b1, addr, data, mask, unused_rdata);
        key = ram_key(addr);
        if (addr[31:28] == REGION_RAM) begin
            if (ram_model.exists(key))
                ram_model[key] = merge_bytes(ram_model[key], data, mask);
            else if (mask == 4'hf)
                ram_model[key] = data;
        end
    endtask

    task automatic read_op(input logic [31:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic [31:0] want;
        int unsigned key;
        want = expected;
        key  = ram_key(addr);
        // RAM words written earlier take their value from the merged model
        if (addr[31:28] == REGION_RAM && ram_model.exists(key)) begin
            checks++;
            assert (ram_model[key] === expected) else begin
                $display("Stim error: expected word %h at %h differs from the RAM model %h",
                         expected, addr, ram_model[key]);
                note_error();
            end
            want = ram_model[key];
        end
        bus_access(1'b0, addr, 32'd0, 4'h0, rdata);
        check_value("rdata", want, rdata);
    endtask

    task automatic strobe_codes(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            kbd_code   = first[7:0] + 8'(i);
            kbd_strobe = 1'b1;
        end
        @(negedge clk);
        kbd_strobe = 1'b0;
    endtask

    // Dequeue, let the held register settle, then read the code
    task automatic dequeue_codes(input logic [31:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            write_op({REGION_IO, 12'd0, PAGE_KBD, OFS_STATUS}, 32'd0, 4'hf);
            repeat (2) @(negedge clk);
            read_op({REGION_IO, 12'd0, PAGE_KBD, OFS_CODE}, {24'd0, first[7:0] + 8'(i)});
        end
    endtask

    task automatic check_pins(input logic [31:0] disp, input logic [31:0] sd);
        check_value("display_o", {24'd0, disp[7:0]}, {24'd0, display});
        check_value("sd_pins_o", {29'd0, sd[2:0]}, {29'd0, sd_pins});
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            tests++;
            if (test_errors == 0)
                $display("Test %s: ok", test_name);
            else
                $display("Test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic load_stim();
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        int          weight;
        int          idle;
        weight = 0;
        idle   = 0;
        fd = $fopen("tb/soc_stim.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                line = strip_end(line);
                if (line.len() > 0 && line.getc(0) != "#")
                    stim_lines.push_back(line);
            end
        end
        $fclose(fd);
        // Cycle limit of 8 per operation plus all idle cycles and a margin
        foreach (stim_lines[i]) begin
            op = stim_lines[i].getc(0);
            a  = 32'd0;
            b  = 32'd1;
            void'($sscanf(stim_lines[i].substr(1, stim_lines[i].len() - 1), "%h %h", a, b));
            case (op)
                "I":     idle += int'(a);
                "K":     weight += int'(b);
                "D":     weight += 3 * int'(b);
                default: weight += 1;
            endcase
        end
        cycle_limit = 8 * weight + idle + 100;
    endtask

    task automatic run_line(input string line);
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        op = line.getc(0);
        a  = 32'd0;
        b  = 32'd1;
        c  = 32'd0;
        if (op != "T")
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
        case (op)
            "T": begin
                finish_test();
                test_name   = line.substr(2, line.len() - 1);
                test_errors = 0;
            end
            "W": write_op(a, b, c[3:0]);
            "R": read_op(a, b);
            "K": strobe_codes(a, int'(b));
            "D": dequeue_codes(a, int'(b));
            "M": begin
                @(negedge clk);
                sd_miso = a[0];
            end
            "P": check_pins(a, b);
            "I": repeat (int'(a)) @(negedge clk);
            default: begin
                $display("Stim error: unknown operation in line '%s'", line);
                note_error();
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles, limit %0d", cycles, cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        bus_req    = '0;
        sd_miso    = 1'b0;
        kbd_code   = 8'd0;
        kbd_strobe = 1'b0;
        lfsr_state = 32'hee9779c9;
        load_stim();
        assert (stim_lines.size() > 0) else begin
            $display("Stim file tb/soc_stim.txt is missing or holds no operations");
            note_error();
        end
        while (reset !== 1'b0)
            @(negedge clk);
        foreach (stim_lines[i])
            run_line(stim_lines[i]);
        finish_test();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tb/soc_stim.txt */
# Ops, values in hex: W addr data mask | R addr expected | K code [count] | D first count
# M miso | P display sd{sclk,csn,mosi} | I cycles | T test name
T ram
W 10000000 12345678 f
W 10000004 deadbeef f
R 10000000 12345678
R 10000004 deadbeef
W 10000008 11223344 f
W 10000008 aabbccdd 5
R 10000008 11bb33dd
W 10000008 00ee0000 4
R 10000008 11ee33dd
T display
P 00 2
W 20001000 000001a5 f
P a5 2
R 20001000 0
T sd
M 1
W 20006000 7 f
P a5 5
R 20006000 1
W 20006000 3 f
P a5 1
M 0
R 20006000 0
W 20006000 0 f
P a5 2
T kbd_order
K 1c
K 32
K 5a
R 20005000 1
W 20005000 0 f
I 2
R 20005004 1c
W 20005000 0 f
I 2
R 20005004 32
W 20005000 0 f
I 2
R 20005004 5a
R 20005000 0
T kbd_overflow
K 40 22
R 20005000 1
D 40 20
R 20005000 0
T unmapped
R 20003000 0
R 20005008 0
M 1
R 20006004 0
R 30000000 0
W 30000000 ffffffff f
W 20003000 ffffffff f
W 20006004 7 f
P a5 2
R 10000000 12345678

/* sim.f */
common/soc_pkg.sv
keyboard/kbd_fifo.sv
keyboard/kbd_port.sv
bus/bus_decoder.sv
verilog/ram_bank.sv
verilog/io_regs.sv
verilog/soc_top.sv
tb/tb_clock.sv
tb/soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fabric testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module soc_tb -o soc_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/soc_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -qx "=== PASS ===" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi
